// ==== Bender.yml ====
package:
  name: trdb_trace_encoder

sources:
  - files:
      - verilog/trdb_isa_pkg.sv
      - verilog/trdb_pkt_pkg.sv
      - verilog/trdb_stage_pipe.sv
      - verilog/trdb_itype_detector.sv
      - verilog/trdb_branch_map.sv
      - verilog/trdb_packet_emitter.sv
      - verilog/trdb_top.sv
  - target: test
    files:
      - dv/trdb_checker.sv
      - dv/tb_trdb_top.sv

// ==== dv/tb_trdb_top.sv ====
// testbench for the trace encoder top level
// clock, reset, stimulus table and a reference model of the expected packets
`timescale 1ns/10ps

module tb_trdb_top;

    localparam int unsigned MAP_LEN = 4;
    localparam int DRAIN_TIMEOUT = 50;
    // retire to packet strobe in cycles
    localparam int LATENCY = 2;
    localparam logic [1:0] KIND_PLAIN  = 2'd0;
    localparam logic [1:0] KIND_BRANCH = 2'd1;
    localparam logic [1:0] KIND_JALR   = 2'd2;

    // one retire of the table
    typedef struct packed {
        logic [7:0]                    test;
        logic [trdb_isa_pkg::XLEN-1:0] addr;
        logic [trdb_isa_pkg::XLEN-1:0] word;
        logic                          compressed;
        logic                          exception;
        logic [1:0]                    kind;
    } row_t;

    logic                          clk = 1'b0;
    logic                          rst;
    logic                          inst_valid;
    logic [trdb_isa_pkg::XLEN-1:0] iaddr;
    logic [trdb_isa_pkg::XLEN-1:0] inst_data;
    logic                          compressed;
    logic                          exception;
    logic                          packet_valid;
    trdb_pkt_pkg::packet_t         packet;
    logic                          exp_valid;
    trdb_pkt_pkg::packet_t         exp_packet;
    logic                          test_done;
    logic [7:0]                    test_id;
    logic                          summary;
    logic [7:0]                    pending;
    int                            error_count;

    row_t        rows[$];
    logic [31:0] lcg_state = 32'h51d0;
    int          timeouts = 0;

    // reference model state
    logic                           model_started = 1'b0;
    logic [trdb_isa_pkg::XLEN-1:0]  prev_addr;
    logic                           prev_compressed;
    logic                           pend_branch;
    logic                           pend_discon;
    logic [trdb_pkt_pkg::MAP_W-1:0] model_map = '0;
    logic [trdb_pkt_pkg::CNT_W-1:0] model_cnt = '0;

    always #10 clk = ~clk;

    trdb_top #(.MAP_LEN(MAP_LEN)) trdb_top_inst (
        .clk_i(clk), .rst_i(rst), .inst_valid_i(inst_valid), .iaddr_i(iaddr),
        .inst_data_i(inst_data), .compressed_i(compressed), .exception_i(exception),
        .packet_valid_o(packet_valid), .packet_o(packet)
    );

    trdb_checker pkt_checker_inst (
        .clk_i(clk), .rst_i(rst), .packet_valid_i(packet_valid), .packet_i(packet),
        .exp_valid_i(exp_valid), .exp_packet_i(exp_packet), .test_done_i(test_done),
        .test_id_i(test_id), .summary_i(summary), .pending_o(pending),
        .error_count_o(error_count)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // plain rows get a random addi word that matches no branch or jalr
    task automatic add_row(input logic [7:0] test, input logic [31:0] addr,
                           input logic [1:0] kind, input logic [31:0] word,
                           input logic c, input logic e);
        row_t        r;
        logic [31:0] w;
        w = word;
        if (kind == KIND_PLAIN) begin
            lcg_state = lcg_next(lcg_state);
            w = (lcg_state & ~trdb_isa_pkg::MASK_ADDI) | trdb_isa_pkg::MATCH_ADDI;
        end
        r = '{test, addr, w, c, e, kind};
        rows.push_back(r);
    endtask

    task automatic build_table();
        // sync on the first retire then sequential steps of 2 and 4
        add_row(1, 32'h1000, KIND_PLAIN, 0, 1'b1, 1'b0);
        add_row(2, 32'h1002, KIND_PLAIN, 0, 1'b1, 1'b0);
        add_row(2, 32'h1004, KIND_PLAIN, 0, 1'b0, 1'b0);
        add_row(2, 32'h1008, KIND_PLAIN, 0, 1'b0, 1'b0);
        // outcomes beq nt / bltu t / p.beqimm nt / c.bnez nt fill the map
        // the last beq resolves into the new map
        add_row(3, 32'h100c, KIND_BRANCH, 32'h0020_8463, 1'b0, 1'b0);
        add_row(3, 32'h1010, KIND_PLAIN, 0, 1'b0, 1'b0);
        add_row(3, 32'h1014, KIND_BRANCH, 32'h0020_e463, 1'b0, 1'b0);
        add_row(3, 32'h1040, KIND_PLAIN, 0, 1'b0, 1'b0);
        add_row(3, 32'h1044, KIND_BRANCH, 32'h0020_a463, 1'b0, 1'b0);
        add_row(3, 32'h1048, KIND_PLAIN, 0, 1'b0, 1'b0);
        add_row(3, 32'h104c, KIND_BRANCH, 32'h0000_e011, 1'b1, 1'b0);
        add_row(3, 32'h104e, KIND_BRANCH, 32'h0020_8463, 1'b0, 1'b0);
        add_row(3, 32'h1052, KIND_PLAIN, 0, 1'b0, 1'b0);
        // taken bne then jalr to 0x2000
        add_row(4, 32'h1056, KIND_BRANCH, 32'h0020_9463, 1'b0, 1'b0);
        add_row(4, 32'h1080, KIND_PLAIN, 0, 1'b0, 1'b0);
        add_row(4, 32'h1084, KIND_JALR, 32'h0000_8067, 1'b0, 1'b0);
        add_row(4, 32'h2000, KIND_PLAIN, 0, 1'b0, 1'b0);
        // trap into the handler at 0x100
        add_row(5, 32'h2004, KIND_PLAIN, 0, 1'b0, 1'b1);
        add_row(5, 32'h0100, KIND_PLAIN, 0, 1'b0, 1'b0);
        // branch at 0x104 reported twice yet resolved only once
        add_row(6, 32'h0104, KIND_BRANCH, 32'h0020_8463, 1'b0, 1'b0);
        add_row(6, 32'h0104, KIND_BRANCH, 32'h0020_8463, 1'b0, 1'b0);
        add_row(6, 32'h0108, KIND_PLAIN, 0, 1'b0, 1'b0);
        add_row(6, 32'h010c, KIND_JALR, 32'h0000_8067, 1'b0, 1'b0);
        add_row(6, 32'h3000, KIND_PLAIN, 0, 1'b0, 1'b0);
    endtask

    // expected packet of one retire
    task automatic predict(input row_t r, output logic emit, output trdb_pkt_pkg::packet_t p);
        logic taken;
        emit = 1'b0;
        p = '0;
        if (model_started && r.addr == prev_addr) begin
            // repeated report leaves the model alone
            emit = 1'b0;
        end else begin
            if (!model_started) begin
                emit = 1'b1;
                p.format = trdb_pkt_pkg::FMT_SYNC;
                p.body.sync.exception = r.exception;
                p.body.sync.compressed = r.compressed;
                p.body.sync.address = r.addr;
            end else begin
                taken = r.addr != prev_addr + (prev_compressed ? 32'd2 : 32'd4);
                // address after a discontinuity beats a full map
                if (pend_discon || model_cnt == MAP_LEN) begin
                    emit = 1'b1;
                    p.format = pend_discon ? trdb_pkt_pkg::FMT_ADDR : trdb_pkt_pkg::FMT_MAP;
                    p.branch_cnt = model_cnt;
                    p.body.branch.map = model_map;
                    p.body.branch.address = pend_discon ? r.addr : 32'h0;
                    model_map = '0;
                    model_cnt = '0;
                end
                // previous branch resolves here with 1 for not taken
                if (pend_branch) begin
                    model_map[model_cnt] = !taken;
                    model_cnt = model_cnt + 1'b1;
                end
            end
            model_started = 1'b1;
            prev_addr = r.addr;
            prev_compressed = r.compressed;
            pend_branch = (r.kind == KIND_BRANCH);
            pend_discon = (r.kind == KIND_JALR) || r.exception;
        end
    endtask

    // retire on one falling edge and idle on the next
    task automatic apply_row(input row_t r);
        logic                  emit;
        trdb_pkt_pkg::packet_t p;
        predict(r, emit, p);
        inst_valid = 1'b1;
        iaddr = r.addr;
        inst_data = r.word;
        compressed = r.compressed;
        exception = r.exception;
        exp_valid = emit;
        exp_packet = p;
        @(negedge clk);
        inst_valid = 1'b0;
        exp_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic finish_test(input logic [7:0] test);
        int waited;
        waited = 0;
        while (pending != 0 && waited < DRAIN_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (pending != 0) begin
            $display("test %0d: timed out waiting for expected packets", test);
            timeouts++;
        end
        // a stray packet of the last retire shows within the latency
        repeat (LATENCY) @(negedge clk);
        test_id = test;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
    endtask

    initial begin
        rst = 1'b1;
        inst_valid = 1'b0;
        iaddr = '0;
        inst_data = '0;
        compressed = 1'b0;
        exception = 1'b0;
        exp_valid = 1'b0;
        exp_packet = '0;
        test_done = 1'b0;
        test_id = '0;
        summary = 1'b0;
        build_table();
        repeat (5) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            if (i == rows.size() - 1 || rows[i + 1].test != rows[i].test) begin
                finish_test(rows[i].test);
            end
        end
        summary = 1'b1;
        @(negedge clk);
        summary = 1'b0;
        if (error_count == 0 && timeouts == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== dv/trdb_checker.sv ====
// packet checker, queue of expected packets and field compare
// per-test result lines and the closing count line
`timescale 1ns/10ps

module trdb_checker (
    input  logic                  clk_i,
    input  logic                  rst_i,
    input  logic                  packet_valid_i,
    input  trdb_pkt_pkg::packet_t packet_i,
    input  logic                  exp_valid_i,
    input  trdb_pkt_pkg::packet_t exp_packet_i,
    input  logic                  test_done_i,
    input  logic [7:0]            test_id_i,
    input  logic                  summary_i,
    output logic [7:0]            pending_o,
    output int                    error_count_o
);

    trdb_pkt_pkg::packet_t exp_q[$];
    trdb_pkt_pkg::packet_t front;
    int test_errors;
    int unexpected;
    int checked;
    int tests_run;
    int tests_failed;

    task automatic compare_field(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
        if (exp !== act) begin
            $display("FAILED at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
            test_errors++;
        end
    endtask

    // body read through the union, by format
    task automatic compare_packet(input trdb_pkt_pkg::packet_t exp,
                                  input trdb_pkt_pkg::packet_t act);
        trdb_pkt_pkg::pkt_body_u eb;
        trdb_pkt_pkg::pkt_body_u ab;
        eb = exp.body;
        ab = act.body;
        compare_field("packet_o.format", exp.format, act.format);
        compare_field("packet_o.branch_cnt", exp.branch_cnt, act.branch_cnt);
        if (exp.format == trdb_pkt_pkg::FMT_SYNC) begin
            compare_field("packet_o.sync.reserved", eb.sync.reserved, ab.sync.reserved);
            compare_field("packet_o.sync.exception", eb.sync.exception, ab.sync.exception);
            compare_field("packet_o.sync.compressed", eb.sync.compressed, ab.sync.compressed);
            compare_field("packet_o.sync.address", eb.sync.address, ab.sync.address);
        end else begin
            compare_field("packet_o.branch.map", eb.branch.map, ab.branch.map);
            compare_field("packet_o.branch.address", eb.branch.address, ab.branch.address);
            compare_field("packet_o.branch.spare", eb.branch.spare, ab.branch.spare);
        end
        checked++;
    endtask

    task automatic close_test();
        if (exp_q.size() != 0) begin
            $display("test %0d: %0d expected packets never arrived", test_id_i, exp_q.size());
            test_errors += exp_q.size();
            exp_q.delete();
        end
        if (unexpected != 0) begin
            $display("test %0d: %0d packets arrived that were not expected", test_id_i, unexpected);
            test_errors += unexpected;
        end
        tests_run++;
        if (test_errors == 0) begin
            $display("test %0d: passed, %0d packets checked", test_id_i, checked);
        end else begin
            $display("test %0d: failed with %0d errors", test_id_i, test_errors);
            tests_failed++;
        end
        error_count_o += test_errors;
        test_errors = 0;
        unexpected = 0;
        checked = 0;
    endtask

    always @(posedge clk_i) begin
        if (rst_i) begin
            exp_q.delete();
            test_errors = 0;
            unexpected = 0;
            checked = 0;
            tests_run = 0;
            tests_failed = 0;
            error_count_o = 0;
            pending_o = '0;
        end else begin
            // new expectation first, a packet in the same edge is an older one
            if (exp_valid_i) begin
                exp_q.push_back(exp_packet_i);
            end
            if (packet_valid_i) begin
                if (exp_q.size() == 0) begin
                    $display("packet of format %0d arrived at %0d ns with none expected",
                             packet_i.format, $time);
                    unexpected++;
                end else begin
                    front = exp_q.pop_front();
                    compare_packet(front, packet_i);
                end
            end
            if (test_done_i) begin
                close_test();
            end
            if (summary_i) begin
                $display("%0d tests run, %0d passed, %0d failed, %0d errors", tests_run,
                         tests_run - tests_failed, tests_failed, error_count_o);
            end
            pending_o = 8'(exp_q.size());
        end
    end

endmodule

// ==== flist.f ====
verilog/trdb_isa_pkg.sv
verilog/trdb_pkt_pkg.sv
verilog/trdb_stage_pipe.sv
verilog/trdb_itype_detector.sv
verilog/trdb_branch_map.sv
verilog/trdb_packet_emitter.sv
verilog/trdb_top.sv
dv/trdb_checker.sv
dv/tb_trdb_top.sv

// ==== verilog/trdb_branch_map.sv ====
// branch outcome map, bit per resolved branch
// count and full flag for the packet emitter
`timescale 1ns/10ps

module trdb_branch_map #(
    parameter int unsigned MAP_LEN = 16
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              advance_i,
    input  logic                              nc_branch_i,
    input  logic                              tc_branch_taken_i,
    input  logic                              map_flush_i,
    output logic [trdb_pkt_pkg::MAP_W-1:0]    map_bits_o,
    output logic [trdb_pkt_pkg::CNT_W-1:0]    map_count_o,
    output logic                              map_full_o
);

    localparam int unsigned CNT_W = trdb_pkt_pkg::CNT_W;

    // MAP_LEN has to fit the packet field
    if (MAP_LEN < 1 || MAP_LEN > trdb_pkt_pkg::MAP_W) begin : g_bad_len
        $error("MAP_LEN out of range 1..MAP_W");
    end

    // previous nc was a branch, resolved on the next advance
    logic                          pending_q;
    logic                          append;
    logic                          outcome;
    logic [trdb_pkt_pkg::MAP_W-1:0] map_q;
    logic [CNT_W-1:0]              count_q;

    assign append  = advance_i && pending_q;
    // 1 marks not taken
    assign outcome = !tc_branch_taken_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            pending_q <= 1'b0;
            map_q     <= '0;
            count_q   <= '0;
        end else begin
            if (advance_i) begin
                pending_q <= nc_branch_i;
            end
            if (map_flush_i) begin
                // flush wins, a bit resolved now opens the new map
                map_q   <= '0;
                count_q <= '0;
                if (append) begin
                    map_q[0] <= outcome;
                    count_q  <= CNT_W'(1);
                end
            end else if (append) begin
                map_q[count_q] <= outcome;
                count_q        <= count_q + CNT_W'(1);
            end
        end
    end

    assign map_bits_o  = map_q;
    assign map_count_o = count_q;
    assign map_full_o  = (count_q == CNT_W'(MAP_LEN));

    a_count_bound: assert property (@(posedge clk_i) disable iff (rst_i)
        count_q <= CNT_W'(MAP_LEN));

    // emitter must drain a full map before another bit lands
    a_full_drained: assert property (@(posedge clk_i) disable iff (rst_i)
        (append && map_full_o) |-> map_flush_i);

endmodule

// ==== verilog/trdb_isa_pkg.sv ====
// instruction and address width
// mask/match pairs for conditional branches, pulp immediate branches,
// compressed branches and jalr
package trdb_isa_pkg;

    // core word size, used for both addresses and instruction words
    localparam int unsigned XLEN = 32;

    // rv32i conditional branches
    // opcode 1100011, funct3 selects the compare
    localparam logic [XLEN-1:0] MASK_BEQ  = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_BEQ = 32'h0000_0063;

    localparam logic [XLEN-1:0] MASK_BNE  = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_BNE = 32'h0000_1063;

    localparam logic [XLEN-1:0] MASK_BLT  = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_BLT = 32'h0000_4063;

    localparam logic [XLEN-1:0] MASK_BGE  = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_BGE = 32'h0000_5063;

    localparam logic [XLEN-1:0] MASK_BLTU  = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_BLTU = 32'h0000_6063;

    localparam logic [XLEN-1:0] MASK_BGEU  = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_BGEU = 32'h0000_7063;

    // pulp immediate branches
    // reuse the two free funct3 slots of the branch opcode
    localparam logic [XLEN-1:0] MASK_P_BEQIMM  = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_P_BEQIMM = 32'h0000_2063;

    localparam logic [XLEN-1:0] MASK_P_BNEIMM  = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_P_BNEIMM = 32'h0000_3063;

    // compressed branches, quadrant 1
    // only the low halfword is meaningful
    localparam logic [XLEN-1:0] MASK_C_BEQZ  = 32'h0000_e003;
    localparam logic [XLEN-1:0] MATCH_C_BEQZ = 32'h0000_c001;

    localparam logic [XLEN-1:0] MASK_C_BNEZ  = 32'h0000_e003;
    localparam logic [XLEN-1:0] MATCH_C_BNEZ = 32'h0000_e001;

    // indirect jump, target not inferable from the program
    localparam logic [XLEN-1:0] MASK_JALR  = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_JALR = 32'h0000_0067;

    // addi, for reference when building filler words
    localparam logic [XLEN-1:0] MASK_ADDI  = 32'h0000_707f;
    localparam logic [XLEN-1:0] MATCH_ADDI = 32'h0000_0013;

endpackage

// ==== verilog/trdb_itype_detector.sv ====
// classification of the tc/nc pair
// branch, taken and uninferable discontinuity flags
`timescale 1ns/10ps

module trdb_itype_detector (
    input  logic                           tc_ready_i,
    input  logic                           nc_ready_i,
    input  logic [trdb_isa_pkg::XLEN-1:0]  nc_inst_data_i,
    input  logic                           tc_compressed_i,
    input  logic [trdb_isa_pkg::XLEN-1:0]  tc_iaddr_i,
    input  logic [trdb_isa_pkg::XLEN-1:0]  nc_iaddr_i,
    input  logic                           nc_exception_i,
    output logic                           nc_branch_o,
    output logic                           tc_branch_taken_o,
    output logic                           nc_updiscon_o
);

    logic                          both_ready;
    logic                          same_instr;
    logic                          nc_is_branch;
    logic                          nc_is_jalr;
    logic [trdb_isa_pkg::XLEN-1:0] tc_next_iaddr;

    assign both_ready = tc_ready_i && nc_ready_i;
    // repeated report of the same retire
    // only compared once tc holds a real predecessor
    assign same_instr = both_ready && (tc_iaddr_i == nc_iaddr_i);

    // any conditional branch kind
    assign nc_is_branch =
        ((nc_inst_data_i & trdb_isa_pkg::MASK_BEQ)      == trdb_isa_pkg::MATCH_BEQ)      ||
        ((nc_inst_data_i & trdb_isa_pkg::MASK_BNE)      == trdb_isa_pkg::MATCH_BNE)      ||
        ((nc_inst_data_i & trdb_isa_pkg::MASK_BLT)      == trdb_isa_pkg::MATCH_BLT)      ||
        ((nc_inst_data_i & trdb_isa_pkg::MASK_BGE)      == trdb_isa_pkg::MATCH_BGE)      ||
        ((nc_inst_data_i & trdb_isa_pkg::MASK_BLTU)     == trdb_isa_pkg::MATCH_BLTU)     ||
        ((nc_inst_data_i & trdb_isa_pkg::MASK_BGEU)     == trdb_isa_pkg::MATCH_BGEU)     ||
        ((nc_inst_data_i & trdb_isa_pkg::MASK_P_BEQIMM) == trdb_isa_pkg::MATCH_P_BEQIMM) ||
        ((nc_inst_data_i & trdb_isa_pkg::MASK_P_BNEIMM) == trdb_isa_pkg::MATCH_P_BNEIMM) ||
        ((nc_inst_data_i & trdb_isa_pkg::MASK_C_BEQZ)   == trdb_isa_pkg::MATCH_C_BEQZ)   ||
        ((nc_inst_data_i & trdb_isa_pkg::MASK_C_BNEZ)   == trdb_isa_pkg::MATCH_C_BNEZ);

    // c.jr / c.jalr not decoded
    assign nc_is_jalr =
        (nc_inst_data_i & trdb_isa_pkg::MASK_JALR) == trdb_isa_pkg::MATCH_JALR;

    // fall-through address of tc
    assign tc_next_iaddr = tc_iaddr_i + (tc_compressed_i ? trdb_isa_pkg::XLEN'(2)
                                                         : trdb_isa_pkg::XLEN'(4));

    assign nc_branch_o = nc_is_branch && nc_ready_i && !same_instr;

    // taken when nc is not the sequential successor
    assign tc_branch_taken_o = (tc_next_iaddr != nc_iaddr_i) && both_ready && !same_instr;

    // exceptions redirect like an indirect jump
    assign nc_updiscon_o = (nc_is_jalr || nc_exception_i) && nc_ready_i && !same_instr;

endmodule

// ==== verilog/trdb_packet_emitter.sv ====
// packet kind selection: sync, address after discontinuity, map when full
// packet assembly through the body union, registered strobe
`timescale 1ns/10ps

module trdb_packet_emitter #(
    parameter int unsigned MAP_LEN = 16
) (
    input  logic                              clk_i,
    input  logic                              rst_i,
    input  logic                              advance_i,
    input  logic [trdb_isa_pkg::XLEN-1:0]     nc_iaddr_i,
    input  logic                              nc_exception_i,
    input  logic                              tc_compressed_i,
    input  logic                              nc_updiscon_i,
    input  logic [trdb_pkt_pkg::MAP_W-1:0]    map_bits_i,
    input  logic [trdb_pkt_pkg::CNT_W-1:0]    map_count_i,
    input  logic                              map_full_i,
    output logic                              map_flush_o,
    output logic                              packet_valid_o,
    output trdb_pkt_pkg::packet_t             packet_o
);

    localparam int unsigned MAP_W = trdb_pkt_pkg::MAP_W;
    // keep only the MAP_LEN low bits of the map field
    localparam logic [MAP_W-1:0] MAP_KEEP = {MAP_W{1'b1}} >> (MAP_W - MAP_LEN);

    logic                  need_sync_q;
    logic                  discon_q;
    logic                  emit_sync;
    logic                  emit_addr;
    logic                  emit_map;
    trdb_pkt_pkg::pkt_body_u body;
    trdb_pkt_pkg::packet_t   pkt_next;

    // priority sync > address > map
    assign emit_sync = advance_i && need_sync_q;
    assign emit_addr = advance_i && !need_sync_q && discon_q;
    assign emit_map  = advance_i && !need_sync_q && !discon_q && map_full_i;

    // map clears on the edge that latches the packet
    assign map_flush_o = emit_addr || emit_map;

    always_comb begin
        body = '0;
        if (emit_sync) begin
            // first instruction, tc mirrors nc here
            body.sync.exception  = nc_exception_i;
            body.sync.compressed = tc_compressed_i;
            body.sync.address    = nc_iaddr_i;
        end else begin
            body.branch.map = map_bits_i & MAP_KEEP;
            // map-only packets carry no address
            if (emit_addr) begin
                body.branch.address = nc_iaddr_i;
            end
        end
    end

    always_comb begin
        pkt_next.format     = emit_sync ? trdb_pkt_pkg::FMT_SYNC :
                              emit_addr ? trdb_pkt_pkg::FMT_ADDR : trdb_pkt_pkg::FMT_MAP;
        pkt_next.branch_cnt = emit_sync ? '0 : map_count_i;
        pkt_next.body       = body;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            need_sync_q    <= 1'b1;
            discon_q       <= 1'b0;
            packet_valid_o <= 1'b0;
        end else begin
            packet_valid_o <= emit_sync || emit_addr || emit_map;
            if (advance_i) begin
                need_sync_q <= 1'b0;
                // jalr or exception in nc, address follows on next retire
                discon_q    <= nc_updiscon_i;
            end
        end
    end

    // held until the next packet
    always_ff @(posedge clk_i) begin
        if (emit_sync || emit_addr || emit_map) begin
            packet_o <= pkt_next;
        end
    end

    a_single_pulse: assert property (@(posedge clk_i) disable iff (rst_i)
        packet_valid_o |=> !packet_valid_o);

endmodule

// ==== verilog/trdb_pkt_pkg.sv ====
// packet format codes and field widths
// packed body layouts and the 64-bit trace packet
package trdb_pkt_pkg;

    // format field, 0 left unused
    localparam logic [1:0] FMT_MAP  = 2'd1;
    localparam logic [1:0] FMT_ADDR = 2'd2;
    localparam logic [1:0] FMT_SYNC = 2'd3;

    // map field width, upper bound for MAP_LEN
    localparam int unsigned MAP_W = 24;
    // branch count width, holds 0..MAP_W
    localparam int unsigned CNT_W = 5;
    localparam int unsigned ADDR_W = 32;

    // address and map packets
    // bit i of map is the i-th branch, 1 = not taken
    typedef struct packed {
        logic [MAP_W-1:0]  map;
        logic [ADDR_W-1:0] address;
        logic              spare;
    } branch_body_t;

    // sync packet, full state of the first instruction
    typedef struct packed {
        logic [22:0]       reserved;
        logic              exception;
        logic              compressed;
        logic [ADDR_W-1:0] address;
    } sync_body_t;

    // same 57 bits, read according to format
    typedef union packed {
        branch_body_t branch;
        sync_body_t   sync;
    } pkt_body_u;

    // 2 + 5 + 57 = 64 bits
    typedef struct packed {
        logic [1:0]       format;
        logic [CNT_W-1:0] branch_cnt;
        pkt_body_u        body;
    } packet_t;

endpackage

// ==== verilog/trdb_stage_pipe.sv ====
// two-entry retire stage, current (tc) and next (nc) instruction
// advance pulse one cycle after each retire
`timescale 1ns/10ps

module trdb_stage_pipe (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           inst_valid_i,
    input  logic [trdb_isa_pkg::XLEN-1:0]  iaddr_i,
    input  logic [trdb_isa_pkg::XLEN-1:0]  inst_data_i,
    input  logic                           compressed_i,
    input  logic                           exception_i,
    output logic                           tc_ready_o,
    output logic [trdb_isa_pkg::XLEN-1:0]  tc_iaddr_o,
    output logic                           tc_compressed_o,
    output logic                           nc_ready_o,
    output logic [trdb_isa_pkg::XLEN-1:0]  nc_iaddr_o,
    output logic [trdb_isa_pkg::XLEN-1:0]  nc_inst_data_o,
    output logic                           nc_exception_o,
    output logic                           advance_o
);

    // nc compressed flag only travels on into tc
    logic nc_compressed_q;

    // control flags
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tc_ready_o <= 1'b0;
            nc_ready_o <= 1'b0;
            advance_o  <= 1'b0;
        end else begin
            advance_o <= inst_valid_i;
            if (inst_valid_i) begin
                // fill in order: nc first, tc one retire later
                tc_ready_o <= nc_ready_o;
                nc_ready_o <= 1'b1;
            end
        end
    end

    // payload shift
    always_ff @(posedge clk_i) begin
        if (inst_valid_i) begin
            // with nc still empty, tc mirrors the new instruction
            // so the first advance sees its compressed flag
            tc_iaddr_o      <= nc_ready_o ? nc_iaddr_o : iaddr_i;
            tc_compressed_o <= nc_ready_o ? nc_compressed_q : compressed_i;
            nc_iaddr_o      <= iaddr_i;
            nc_inst_data_o  <= inst_data_i;
            nc_compressed_q <= compressed_i;
            nc_exception_o  <= exception_i;
        end
    end

    // core retires at most every other cycle
    a_retire_spacing: assert property (@(posedge clk_i) disable iff (rst_i)
        inst_valid_i |=> !inst_valid_i);

endmodule

// ==== verilog/trdb_top.sv ====
// trace encoder top level
// stage pipe, type detector, branch map and packet emitter
`timescale 1ns/10ps

module trdb_top #(
    parameter int unsigned MAP_LEN = 16
) (
    input  logic                           clk_i,
    input  logic                           rst_i,
    input  logic                           inst_valid_i,
    input  logic [trdb_isa_pkg::XLEN-1:0]  iaddr_i,
    input  logic [trdb_isa_pkg::XLEN-1:0]  inst_data_i,
    input  logic                           compressed_i,
    input  logic                           exception_i,
    output logic                           packet_valid_o,
    output trdb_pkt_pkg::packet_t          packet_o
);

    // stage outputs
    logic                          tc_ready;
    logic [trdb_isa_pkg::XLEN-1:0] tc_iaddr;
    logic                          tc_compressed;
    logic                          nc_ready;
    logic [trdb_isa_pkg::XLEN-1:0] nc_iaddr;
    logic [trdb_isa_pkg::XLEN-1:0] nc_inst_data;
    logic                          nc_exception;
    logic                          advance;
    // detector flags
    logic                          nc_branch;
    logic                          tc_branch_taken;
    logic                          nc_updiscon;
    // map state and flush
    logic [trdb_pkt_pkg::MAP_W-1:0] map_bits;
    logic [trdb_pkt_pkg::CNT_W-1:0] map_count;
    logic                           map_full;
    logic                           map_flush;

    trdb_stage_pipe stage_pipe_inst (
        .clk_i, .rst_i, .inst_valid_i, .iaddr_i, .inst_data_i, .compressed_i, .exception_i,
        .tc_ready_o(tc_ready), .tc_iaddr_o(tc_iaddr), .tc_compressed_o(tc_compressed),
        .nc_ready_o(nc_ready), .nc_iaddr_o(nc_iaddr), .nc_inst_data_o(nc_inst_data),
        .nc_exception_o(nc_exception), .advance_o(advance)
    );

    trdb_itype_detector itype_detector_inst (
        .tc_ready_i(tc_ready), .nc_ready_i(nc_ready), .nc_inst_data_i(nc_inst_data),
        .tc_compressed_i(tc_compressed), .tc_iaddr_i(tc_iaddr), .nc_iaddr_i(nc_iaddr),
        .nc_exception_i(nc_exception), .nc_branch_o(nc_branch),
        .tc_branch_taken_o(tc_branch_taken), .nc_updiscon_o(nc_updiscon)
    );

    trdb_branch_map #(.MAP_LEN(MAP_LEN)) branch_map_inst (
        .clk_i, .rst_i, .advance_i(advance), .nc_branch_i(nc_branch),
        .tc_branch_taken_i(tc_branch_taken), .map_flush_i(map_flush),
        .map_bits_o(map_bits), .map_count_o(map_count), .map_full_o(map_full)
    );

    trdb_packet_emitter #(.MAP_LEN(MAP_LEN)) packet_emitter_inst (
        .clk_i, .rst_i, .advance_i(advance), .nc_iaddr_i(nc_iaddr),
        .nc_exception_i(nc_exception), .tc_compressed_i(tc_compressed),
        .nc_updiscon_i(nc_updiscon), .map_bits_i(map_bits), .map_count_i(map_count),
        .map_full_i(map_full), .map_flush_o(map_flush),
        .packet_valid_o, .packet_o
    );

endmodule
